// ==== design/cmt_pkg.sv ====
//************************************************************
// Commit stage package: slot sizes, data widths, opcodes,
// FSM states, system register indices and vector offsets
//************************************************************
`default_nettype none

package cmt_pkg;

   localparam int P_COMMIT_WIDTH = 2;        // log2 of commit slots
   localparam int CW             = 1 << P_COMMIT_WIDTH;
   localparam int PC_W           = 30;       // Word-addressed PC
   localparam int DW             = 32;
   localparam int PRF_AW         = 6;
   localparam int NUM_SR         = 4;        // Scratch registers
   localparam int PSR_W          = 8;

   // Offsets added to EVECT
   localparam logic [PC_W-1:0] VEC_SYSCALL = 8;
   localparam logic [PC_W-1:0] VEC_EINSN   = 4;

   typedef enum logic [1:0] {
      LSU_NONE  = 2'd0,
      LSU_LOAD  = 2'd1,
      LSU_STORE = 2'd2
   } lsu_op_t;

   typedef enum logic [2:0] {
      EPU_NONE    = 3'd0,
      EPU_MFSR    = 3'd1,
      EPU_MTSR    = 3'd2,
      EPU_SYSCALL = 3'd3,
      EPU_ERET    = 3'd4
   } epu_op_t;

   typedef enum logic {
      S_IDLE,
      S_PENDING
   } req_state_t;

   typedef enum logic [2:0] {
      MSR_PSR   = 3'd0,
      MSR_EPC   = 3'd1,
      MSR_EPSR  = 3'd2,
      MSR_EVECT = 3'd3,
      MSR_SR0   = 3'd4,
      MSR_SR1   = 3'd5,
      MSR_SR2   = 3'd6,
      MSR_SR3   = 3'd7
   } msr_idx_t;

endpackage

`default_nettype wire

// ==== design/cmt_epu_if.sv ====
//************************************************************
// Request/answer bundle between slot control, the
// exception unit and flush control
//************************************************************
`timescale 1ns/100ps
`default_nettype none

interface cmt_epu_if;
   import cmt_pkg::*;

   logic            req;        // One-cycle strobe
   epu_op_t         op;
   logic            exc;
   logic [PC_W-1:0] pc;
   logic [DW-1:0]   opera;
   logic [DW-1:0]   operb;

   logic            done;       // Exactly one cycle after req
   logic [DW-1:0]   wb_dout;
   logic            exc_flush;  // Valid with done only
   logic [PC_W-1:0] exc_tgt;
   logic            refetch;    // Valid with done only

   modport ctl (output req, op, exc, pc, opera, operb, input done, wb_dout);
   modport epu (input req, op, exc, pc, opera, operb,
                output done, wb_dout, exc_flush, exc_tgt, refetch);
   modport mon (input done, exc_flush, exc_tgt, refetch);

endinterface

`default_nettype wire

// ==== design/cmt_msr_if.sv ====
//************************************************************
// Exception unit to system register block bundle
//************************************************************
`timescale 1ns/100ps
`default_nettype none

interface cmt_msr_if;
   import cmt_pkg::*;

   msr_idx_t        rd_idx;
   logic            we;         // Applied at the next edge
   msr_idx_t        wr_idx;
   logic [DW-1:0]   wdata;
   logic            save;       // PSR to EPSR, save_pc to EPC
   logic [PC_W-1:0] save_pc;
   logic            restore;    // EPSR back to PSR

   logic [DW-1:0]   rd_data;
   logic [PC_W-1:0] epc;
   logic [PC_W-1:0] evect;

   modport epu (output rd_idx, we, wr_idx, wdata, save, save_pc, restore,
                input rd_data, epc, evect);
   modport msr (input rd_idx, we, wr_idx, wdata, save, save_pc, restore,
                output rd_data, epc, evect);

endinterface

`default_nettype wire

// ==== design/cmt_msr.sv ====
//************************************************************
// System registers: PSR, EPC, EPSR, EVECT and scratch
//************************************************************
`timescale 1ns/100ps
`default_nettype none

module cmt_msr
#(
   parameter logic [cmt_pkg::PC_W-1:0] EVECT_RST = '0
)
(
   input  logic    clk,
   input  logic    rst,
   cmt_msr_if.msr  msr
);
   import cmt_pkg::*;

   logic [PSR_W-1:0] psr_r;
   logic [PSR_W-1:0] epsr_r;
   logic [PC_W-1:0]  epc_r;
   logic [PC_W-1:0]  evect_r;
   logic [DW-1:0]    sr_r [NUM_SR];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         psr_r   <= '0;
         epsr_r  <= '0;
         epc_r   <= '0;
         evect_r <= EVECT_RST;
         for (int i = 0; i < NUM_SR; i++)
            sr_r[i] <= '0;
      end
      else
      begin
         if (msr.save)
         begin
            epc_r  <= msr.save_pc;
            epsr_r <= psr_r;
         end
         if (msr.restore)
            psr_r <= epsr_r;
         if (msr.we)
         begin
            case (msr.wr_idx)
               MSR_PSR:   psr_r   <= msr.wdata[PSR_W-1:0];
               MSR_EPC:   epc_r   <= msr.wdata[PC_W-1:0];
               MSR_EPSR:  epsr_r  <= msr.wdata[PSR_W-1:0];
               MSR_EVECT: evect_r <= msr.wdata[PC_W-1:0];
               default:   sr_r[msr.wr_idx[1:0]] <= msr.wdata;   // SR0..SR3
            endcase
         end
      end
   end

   always_comb
   begin
      case (msr.rd_idx)
         MSR_PSR:   msr.rd_data = DW'(psr_r);
         MSR_EPC:   msr.rd_data = DW'(epc_r);
         MSR_EPSR:  msr.rd_data = DW'(epsr_r);
         MSR_EVECT: msr.rd_data = DW'(evect_r);
         default:   msr.rd_data = sr_r[msr.rd_idx[1:0]];
      endcase
   end

   assign msr.epc   = epc_r;
   assign msr.evect = evect_r;

   // MTSR and ERET are separate instructions
   assert property (@(posedge clk) disable iff (rst) !(msr.we && msr.restore));

endmodule

`default_nettype wire

// ==== design/cmt_epu.sv ====
//************************************************************
// Exception unit: system register moves, syscall,
// exception return and illegal-instruction trap
//************************************************************
`timescale 1ns/100ps
`default_nettype none

module cmt_epu
(
   input  logic    clk,
   input  logic    rst,
   cmt_epu_if.epu  epu,
   cmt_msr_if.epu  msr
);
   import cmt_pkg::*;

   logic            req_r;
   logic            exc_r;
   epu_op_t         op_r;
   msr_idx_t        idx_r;
   logic [PC_W-1:0] pc_r;
   logic [DW-1:0]   wdat_r;
   logic            is_exc;
   logic            is_sys;
   logic            is_eret;
   logic            is_mtsr;

   always_ff @(posedge clk)
   begin
      if (rst)
         req_r <= 1'b0;
      else
         req_r <= epu.req;
   end

   always_ff @(posedge clk)
   begin
      if (epu.req)
      begin
         exc_r  <= epu.exc;
         op_r   <= epu.op;
         idx_r  <= msr_idx_t'(epu.opera[2:0]);   // Register index from opera
         pc_r   <= epu.pc;
         wdat_r <= epu.operb;
      end
   end

   // An illegal instruction overrides its opcode
   assign is_exc  = req_r & exc_r;
   assign is_sys  = req_r & ~exc_r & (op_r == EPU_SYSCALL);
   assign is_eret = req_r & ~exc_r & (op_r == EPU_ERET);
   assign is_mtsr = req_r & ~exc_r & (op_r == EPU_MTSR);

   assign msr.rd_idx  = idx_r;
   assign msr.wr_idx  = idx_r;
   assign msr.we      = is_mtsr;
   assign msr.wdata   = wdat_r;
   assign msr.save    = is_exc | is_sys;
   assign msr.save_pc = pc_r;
   assign msr.restore = is_eret;

   assign epu.done      = req_r;
   assign epu.wb_dout   = msr.rd_data;               // MFSR result
   assign epu.exc_flush = is_exc | is_sys | is_eret;
   assign epu.refetch   = is_mtsr;

   always_comb
   begin
      if (is_exc)
         epu.exc_tgt = msr.evect + VEC_EINSN;
      else if (is_sys)
         epu.exc_tgt = msr.evect + VEC_SYSCALL;
      else
         epu.exc_tgt = msr.epc;                      // ERET
   end

   // Requests are single strobes from slot control
   assert property (@(posedge clk) disable iff (rst) epu.done |=> !epu.done);

endmodule

`default_nettype wire

// ==== design/cmt_flush_ctl.sv ====
//************************************************************
// Flush control: speculative flush register, flush
// priority and branch predictor update from slot 0
//************************************************************
`timescale 1ns/100ps
`default_nettype none

module cmt_flush_ctl
#(
   parameter int P_COMMIT_WIDTH = 2
)
(
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      fire0,
   input  logic                      cmt_fls0,
   input  logic [cmt_pkg::PC_W-1:0]  cmt_fls_tgt0,
   input  logic [cmt_pkg::PC_W-1:0]  cmt_pc0,
   input  logic                      cmt_is_bcc0,
   input  logic                      cmt_is_breg0,
   input  logic                      cmt_is_brel0,
   input  logic                      cmt_bpu_taken,
   input  logic [cmt_pkg::PC_W-1:0]  cmt_bpu_tgt,
   cmt_epu_if.mon                    epu,
   output logic                      flush,
   output logic [cmt_pkg::PC_W-1:0]  flush_tgt,
   output logic                      spec_flush,
   output logic                      bpu_wb,
   output logic                      bpu_wb_is_bcc,
   output logic                      bpu_wb_is_breg,
   output logic                      bpu_wb_is_brel,
   output logic                      bpu_wb_taken,
   output logic [cmt_pkg::PC_W-1:0]  bpu_wb_pc,
   output logic [cmt_pkg::PC_W-1:0]  bpu_wb_npc_act
);
   import cmt_pkg::*;

   logic            spec_nxt;
   logic [PC_W-1:0] spec_tgt;
   logic [PC_W-1:0] npc0;

   assign npc0     = cmt_pc0 + PC_W'(1);
   assign spec_nxt = (cmt_fls0 | (epu.done & epu.refetch)) & ~spec_flush;

   // Set at the slot 0 retire, clears itself a cycle later
   always_ff @(posedge clk)
   begin
      if (rst)
         spec_flush <= 1'b0;
      else if (fire0 | spec_flush)
         spec_flush <= spec_nxt;
   end

   always_ff @(posedge clk)
   begin
      if (fire0)
         spec_tgt <= cmt_fls0 ? cmt_fls_tgt0 : npc0;   // Refetch restarts at pc0+1
   end

   assign flush     = spec_flush | (epu.done & epu.exc_flush);
   assign flush_tgt = spec_flush ? spec_tgt : epu.exc_tgt;   // Speculative flush wins

   assign bpu_wb         = fire0 & (cmt_is_bcc0 | cmt_is_breg0 | cmt_is_brel0);
   assign bpu_wb_is_bcc  = cmt_is_bcc0;
   assign bpu_wb_is_breg = cmt_is_breg0;
   assign bpu_wb_is_brel = cmt_is_brel0;
   assign bpu_wb_taken   = cmt_bpu_taken ^ cmt_fls0;           // Mispredict flips it
   assign bpu_wb_pc      = cmt_pc0;
   assign bpu_wb_npc_act = cmt_fls0 ? cmt_fls_tgt0 : cmt_bpu_tgt;

endmodule

`default_nettype wire

// ==== design/cmt_fire_ctl.sv ====
//************************************************************
// Retire control: slot classes, retire mask, unit request
// FSM, retire count and load/system writeback
//************************************************************
`timescale 1ns/100ps
`default_nettype none

module cmt_fire_ctl
#(
   parameter int P_COMMIT_WIDTH = 2
)
(
   input  logic                                             clk,
   input  logic                                             rst,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                   cmt_valid,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                   cmt_is_bcc,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                   cmt_is_breg,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                   cmt_is_brel,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                   cmt_fls,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                   cmt_exc,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                   cmt_prd_we,
   input  cmt_pkg::lsu_op_t [(1<<P_COMMIT_WIDTH)-1:0]       cmt_lsu_op,
   input  cmt_pkg::epu_op_t [(1<<P_COMMIT_WIDTH)-1:0]       cmt_epu_op,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0][cmt_pkg::PC_W-1:0] cmt_pc,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0][cmt_pkg::PRF_AW-1:0] cmt_prd,
   input  logic [cmt_pkg::DW-1:0]                           cmt_opera,
   input  logic [cmt_pkg::DW-1:0]                           cmt_operb,
   input  logic                                             flush,
   input  logic                                             spec_flush,
   input  logic                                             lsu_done,
   input  logic [cmt_pkg::DW-1:0]                           lsu_rdata,
   output logic [(1<<P_COMMIT_WIDTH)-1:0]                   cmt_fire,
   output logic [P_COMMIT_WIDTH:0]                          cmt_pop_size,
   output logic                                             prf_we,
   output logic [cmt_pkg::PRF_AW-1:0]                       prf_waddr,
   output logic [cmt_pkg::DW-1:0]                           prf_wdata,
   output logic                                             lsu_req,
   output cmt_pkg::lsu_op_t                                 lsu_op,
   output logic [cmt_pkg::DW-1:0]                           lsu_addr,
   output logic [cmt_pkg::DW-1:0]                           lsu_wdat,
   cmt_epu_if.ctl                                           epu
);
   import cmt_pkg::*;

   localparam int CW = 1 << P_COMMIT_WIDTH;

   logic [CW-1:0] need_lsu;
   logic [CW-1:0] need_epu;
   logic [CW-1:0] single_fu;
   logic [CW-1:0] cmt_mask;
   logic [CW-1:0] ready;
   logic          unit_req;
   logic          unit_done;
   logic          ld_done;
   req_state_t    state;
   req_state_t    state_nxt;

   always_comb
   begin
      for (int i = 0; i < CW; i++)
      begin
         // An excepting load/store goes to the EPU only
         need_lsu[i] = ~spec_flush & ~cmt_exc[i] & (cmt_lsu_op[i] != LSU_NONE);
         need_epu[i] = ~spec_flush & ((cmt_epu_op[i] != EPU_NONE) | cmt_exc[i]);
         single_fu[i] = need_lsu[i] | need_epu[i] | cmt_fls[i]
                        | cmt_is_bcc[i] | cmt_is_breg[i] | cmt_is_brel[i];
      end
   end

   // Slot j retires only if slots 0..j are all plain
   always_comb
   begin
      cmt_mask[0] = 1'b1;
      for (int j = 1; j < CW; j++)
         cmt_mask[j] = cmt_mask[j-1] & ~single_fu[j-1] & ~single_fu[j];
   end

   assign ready     = cmt_valid & cmt_mask;
   assign unit_req  = ready[0] & (need_lsu[0] | need_epu[0]);
   assign unit_done = lsu_done | epu.done;
   assign cmt_fire  = ready & {CW{(~unit_req | unit_done) & ~flush}};

   assign lsu_req = (state == S_IDLE) & ready[0] & need_lsu[0];
   assign epu.req = (state == S_IDLE) & ready[0] & need_epu[0];

   always_comb
   begin
      state_nxt = state;
      case (state)
         S_IDLE:
            if (lsu_req | epu.req)
               state_nxt = S_PENDING;
         S_PENDING:
            if (unit_done)
               state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         state <= S_IDLE;
      else
         state <= state_nxt;
   end

   always_comb
   begin
      cmt_pop_size = '0;
      for (int i = 0; i < CW; i++)
         cmt_pop_size = cmt_pop_size + {{P_COMMIT_WIDTH{1'b0}}, cmt_fire[i]};
   end

   // Stores finish without a register result
   assign ld_done   = lsu_done & (cmt_lsu_op[0] == LSU_LOAD);
   assign prf_we    = cmt_fire[0] & cmt_prd_we[0] & (epu.done | ld_done);
   assign prf_waddr = cmt_prd[0];
   assign prf_wdata = epu.done ? epu.wb_dout : lsu_rdata;

   assign lsu_op    = cmt_lsu_op[0];
   assign lsu_addr  = cmt_opera;
   assign lsu_wdat  = cmt_operb;
   assign epu.op    = cmt_epu_op[0];
   assign epu.exc   = cmt_exc[0];
   assign epu.pc    = cmt_pc[0];
   assign epu.opera = cmt_opera;
   assign epu.operb = cmt_operb;

   assert property (@(posedge clk) disable iff (rst) !(lsu_req && epu.req));
   // Answers only come back to an open request
   assert property (@(posedge clk) disable iff (rst)
                    (state == S_IDLE) |-> !(lsu_done || epu.done));

endmodule

`default_nettype wire

// ==== design/cmt_top.sv ====
//************************************************************
// Commit stage top: retire control, flush control,
// exception unit and system registers
//************************************************************
`timescale 1ns/100ps
`default_nettype none

module cmt_top
#(
   parameter int P_COMMIT_WIDTH = cmt_pkg::P_COMMIT_WIDTH
)
(
   input  logic                                             clk,
   input  logic                                             rst,
   // Reorder buffer head
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                   cmt_valid,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                   cmt_is_bcc,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                   cmt_is_breg,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                   cmt_is_brel,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                   cmt_fls,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                   cmt_exc,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]                   cmt_prd_we,
   input  cmt_pkg::lsu_op_t [(1<<P_COMMIT_WIDTH)-1:0]       cmt_lsu_op,
   input  cmt_pkg::epu_op_t [(1<<P_COMMIT_WIDTH)-1:0]       cmt_epu_op,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0][cmt_pkg::PC_W-1:0] cmt_pc,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0][cmt_pkg::PC_W-1:0] cmt_fls_tgt,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0][cmt_pkg::PRF_AW-1:0] cmt_prd,
   input  logic [cmt_pkg::DW-1:0]                           cmt_opera,
   input  logic [cmt_pkg::DW-1:0]                           cmt_operb,
   input  logic                                             cmt_bpu_taken,
   input  logic [cmt_pkg::PC_W-1:0]                         cmt_bpu_tgt,
   // To reorder buffer
   output logic [(1<<P_COMMIT_WIDTH)-1:0]                   cmt_fire,
   output logic [P_COMMIT_WIDTH:0]                          cmt_pop_size,
   // Pipeline flush
   output logic                                             flush,
   output logic [cmt_pkg::PC_W-1:0]                         flush_tgt,
   // Register file writeback
   output logic                                             prf_we,
   output logic [cmt_pkg::PRF_AW-1:0]                       prf_waddr,
   output logic [cmt_pkg::DW-1:0]                           prf_wdata,
   // Branch predictor update
   output logic                                             bpu_wb,
   output logic                                             bpu_wb_is_bcc,
   output logic                                             bpu_wb_is_breg,
   output logic                                             bpu_wb_is_brel,
   output logic                                             bpu_wb_taken,
   output logic [cmt_pkg::PC_W-1:0]                         bpu_wb_pc,
   output logic [cmt_pkg::PC_W-1:0]                         bpu_wb_npc_act,
   // Load/store port
   output logic                                             lsu_req,
   output cmt_pkg::lsu_op_t                                 lsu_op,
   output logic [cmt_pkg::DW-1:0]                           lsu_addr,
   output logic [cmt_pkg::DW-1:0]                           lsu_wdat,
   input  logic                                             lsu_done,
   input  logic [cmt_pkg::DW-1:0]                           lsu_rdata
);
   logic spec_flush;

   cmt_epu_if epu_if ();
   cmt_msr_if msr_if ();

   cmt_fire_ctl #(.P_COMMIT_WIDTH(P_COMMIT_WIDTH)) u_fire_ctl (
      .clk, .rst, .cmt_valid, .cmt_is_bcc, .cmt_is_breg, .cmt_is_brel,
      .cmt_fls, .cmt_exc, .cmt_prd_we, .cmt_lsu_op, .cmt_epu_op, .cmt_pc,
      .cmt_prd, .cmt_opera, .cmt_operb, .flush, .spec_flush, .lsu_done,
      .lsu_rdata, .cmt_fire, .cmt_pop_size, .prf_we, .prf_waddr, .prf_wdata,
      .lsu_req, .lsu_op, .lsu_addr, .lsu_wdat, .epu(epu_if)
   );

   cmt_flush_ctl #(.P_COMMIT_WIDTH(P_COMMIT_WIDTH)) u_flush_ctl (
      .clk, .rst,
      .fire0         (cmt_fire[0]),
      .cmt_fls0      (cmt_fls[0]),
      .cmt_fls_tgt0  (cmt_fls_tgt[0]),
      .cmt_pc0       (cmt_pc[0]),
      .cmt_is_bcc0   (cmt_is_bcc[0]),
      .cmt_is_breg0  (cmt_is_breg[0]),
      .cmt_is_brel0  (cmt_is_brel[0]),
      .cmt_bpu_taken, .cmt_bpu_tgt, .epu(epu_if), .flush, .flush_tgt, .spec_flush,
      .bpu_wb, .bpu_wb_is_bcc, .bpu_wb_is_breg, .bpu_wb_is_brel, .bpu_wb_taken,
      .bpu_wb_pc, .bpu_wb_npc_act
   );

   cmt_epu u_epu (.clk, .rst, .epu(epu_if), .msr(msr_if));

   cmt_msr #(.EVECT_RST(256)) u_msr (.clk, .rst, .msr(msr_if));

endmodule

`default_nettype wire

// ==== verif/tb_cmt_vectors.svh ====
//************************************************************
// Row type, stimulus and expected-value table for the
// commit stage testbench
//************************************************************
`ifndef TB_CMT_VECTORS_SVH
`define TB_CMT_VECTORS_SVH

localparam int NUM_ROWS = 15;

typedef struct packed {
   logic [3:0]  valid;     // Slot bits, bit i is slot i
   logic [3:0]  bcc;
   logic [3:0]  fls;
   logic [3:0]  exc;
   logic [3:0]  prd_we;
   logic [7:0]  lsu;       // 2 bits per slot
   logic [11:0] epu;       // 3 bits per slot
   logic [29:0] pc0;       // Slot i gets pc0+i
   logic [29:0] fls_tgt;
   logic [5:0]  prd0;      // Slot i gets prd0+i
   logic [31:0] opera;
   logic [31:0] operb;
   logic        taken;
   logic [29:0] bpu_tgt;
   logic [3:0]  fire;      // Expected from here on
   logic [2:0]  pop;
   logic [1:0]  flush_at;  // 0 none, 1 retire cycle, 2 cycle after
   logic [29:0] tgt;
   logic        prf_we;
   logic [31:0] wdata;
} row_t;

row_t tbl [NUM_ROWS];

task automatic load_table();
   tbl[0]  = '{4'hF, 4'h0, 4'h0, 4'h0, 4'h0, 8'h00, 12'h000, 30'h010, 30'h0, 6'd1, 32'h0,
               32'h0, 1'b0, 30'h0, 4'hF, 3'd4, 2'd0, 30'h0, 1'b0, 32'h0};
   tbl[1]  = '{4'h7, 4'h0, 4'h0, 4'h0, 4'h0, 8'h00, 12'h000, 30'h014, 30'h0, 6'd1, 32'h0,
               32'h0, 1'b0, 30'h0, 4'h7, 3'd3, 2'd0, 30'h0, 1'b0, 32'h0};
   // Branch at slot 2, then at slot 0
   tbl[2]  = '{4'hF, 4'h4, 4'h0, 4'h0, 4'h0, 8'h00, 12'h000, 30'h018, 30'h0, 6'd1, 32'h0,
               32'h0, 1'b1, 30'h1A, 4'h3, 3'd2, 2'd0, 30'h0, 1'b0, 32'h0};
   tbl[3]  = '{4'hF, 4'h1, 4'h0, 4'h0, 4'h0, 8'h00, 12'h000, 30'h01C, 30'h0, 6'd1, 32'h0,
               32'h0, 1'b1, 30'h200, 4'h1, 3'd1, 2'd0, 30'h0, 1'b0, 32'h0};
   // Load at slot 1, load and store at slot 0
   tbl[4]  = '{4'h3, 4'h0, 4'h0, 4'h0, 4'h0, 8'h04, 12'h000, 30'h020, 30'h0, 6'd1, 32'h0,
               32'h0, 1'b0, 30'h0, 4'h1, 3'd1, 2'd0, 30'h0, 1'b0, 32'h0};
   tbl[5]  = '{4'h1, 4'h0, 4'h0, 4'h0, 4'h1, 8'h01, 12'h000, 30'h022, 30'h0, 6'd9, 32'h1234,
               32'h0, 1'b0, 30'h0, 4'h1, 3'd1, 2'd0, 30'h0, 1'b1, 32'hA5A5_1D3B};
   tbl[6]  = '{4'h1, 4'h0, 4'h0, 4'h0, 4'h1, 8'h02, 12'h000, 30'h023, 30'h0, 6'd10, 32'h2000,
               32'h1111_2222, 1'b0, 30'h0, 4'h1, 3'd1, 2'd0, 30'h0, 1'b0, 32'h0};
   tbl[7]  = '{4'hF, 4'h0, 4'h0, 4'h0, 4'h0, 8'h00, 12'h600, 30'h024, 30'h0, 6'd1, 32'h0,
               32'h0, 1'b0, 30'h0, 4'h7, 3'd3, 2'd0, 30'h0, 1'b0, 32'h0};
   // Mispredicted branch at slot 0
   tbl[8]  = '{4'h3, 4'h1, 4'h1, 4'h0, 4'h0, 8'h00, 12'h000, 30'h028, 30'h300, 6'd1, 32'h0,
               32'h0, 1'b0, 30'h029, 4'h1, 3'd1, 2'd2, 30'h300, 1'b0, 32'h0};
   // MTSR then MFSR of SR2
   tbl[9]  = '{4'h1, 4'h0, 4'h0, 4'h0, 4'h0, 8'h00, 12'h002, 30'h040, 30'h0, 6'd1, 32'd6,
               32'hCAFE_0123, 1'b0, 30'h0, 4'h1, 3'd1, 2'd2, 30'h041, 1'b0, 32'h0};
   tbl[10] = '{4'h1, 4'h0, 4'h0, 4'h0, 4'h1, 8'h00, 12'h001, 30'h041, 30'h0, 6'd12, 32'd6,
               32'h0, 1'b0, 30'h0, 4'h1, 3'd1, 2'd0, 30'h0, 1'b1, 32'hCAFE_0123};
   // Syscall, return, illegal instruction
   tbl[11] = '{4'h1, 4'h0, 4'h0, 4'h0, 4'h0, 8'h00, 12'h003, 30'h0A0, 30'h0, 6'd1, 32'h0,
               32'h0, 1'b0, 30'h0, 4'h0, 3'd0, 2'd1, 30'h108, 1'b0, 32'h0};
   tbl[12] = '{4'h1, 4'h0, 4'h0, 4'h0, 4'h0, 8'h00, 12'h004, 30'h0B0, 30'h0, 6'd1, 32'h0,
               32'h0, 1'b0, 30'h0, 4'h0, 3'd0, 2'd1, 30'h0A0, 1'b0, 32'h0};
   tbl[13] = '{4'h1, 4'h0, 4'h0, 4'h1, 4'h0, 8'h00, 12'h000, 30'h0C0, 30'h0, 6'd1, 32'h0,
               32'h0, 1'b0, 30'h0, 4'h0, 3'd0, 2'd1, 30'h104, 1'b0, 32'h0};
   tbl[14] = '{4'h3, 4'h0, 4'h0, 4'h0, 4'h0, 8'h00, 12'h000, 30'h104, 30'h0, 6'd1, 32'h0,
               32'h0, 1'b0, 30'h0, 4'h3, 3'd2, 2'd0, 30'h0, 1'b0, 32'h0};
endtask

`endif

// ==== verif/tb_cmt.sv ====
//************************************************************
// Commit stage testbench: clock, reset, table loop,
// load responder, checks and watchdog
//************************************************************
`timescale 1ns/100ps
`default_nettype none

module tb_cmt;
   import cmt_pkg::*;

   `include "tb_cmt_vectors.svh"

   localparam int PERIOD          = 40;
   localparam int WATCHDOG_CYCLES = NUM_ROWS * 8 + 20;
   localparam logic [DW-1:0] LD_KEY = 32'hA5A5_0F0F;   // Load data is addr ^ key

   logic                               clk = 1'b0;
   logic                               rst = 1'b1;
   logic [CW-1:0]                      cmt_valid, cmt_is_bcc, cmt_is_breg, cmt_is_brel;
   logic [CW-1:0]                      cmt_fls, cmt_exc, cmt_prd_we;
   lsu_op_t [CW-1:0]                   cmt_lsu_op;
   epu_op_t [CW-1:0]                   cmt_epu_op;
   logic [CW-1:0][PC_W-1:0]            cmt_pc, cmt_fls_tgt;
   logic [CW-1:0][PRF_AW-1:0]          cmt_prd;
   logic [DW-1:0]                      cmt_opera, cmt_operb;
   logic                               cmt_bpu_taken;
   logic [PC_W-1:0]                    cmt_bpu_tgt;
   logic [CW-1:0]                      cmt_fire;
   logic [P_COMMIT_WIDTH:0]            cmt_pop_size;
   logic                               flush, prf_we;
   logic [PC_W-1:0]                    flush_tgt;
   logic [PRF_AW-1:0]                  prf_waddr;
   logic [DW-1:0]                      prf_wdata;
   logic                               bpu_wb, bpu_wb_is_bcc, bpu_wb_is_breg, bpu_wb_is_brel;
   logic                               bpu_wb_taken;
   logic [PC_W-1:0]                    bpu_wb_pc, bpu_wb_npc_act;
   logic                               lsu_req;
   lsu_op_t                            lsu_op;
   logic [DW-1:0]                      lsu_addr, lsu_wdat;
   logic                               lsu_done = 1'b0;
   logic [DW-1:0]                      lsu_rdata = '0;

   int            n_checks = 0;
   int            n_errors = 0;
   int            seed = 14814;
   int            ld_delay;
   logic [DW-1:0] ld_addr;

   cmt_top uut (.*);

   always #(PERIOD/2) clk = ~clk;

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
      n_checks++;
      if (got !== want)
      begin
         n_errors++;
         $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
      end
   endtask

   task automatic apply_row(input row_t r);
      for (int i = 0; i < CW; i++)
      begin
         cmt_lsu_op[i]  = lsu_op_t'(r.lsu[2*i +: 2]);
         cmt_epu_op[i]  = epu_op_t'(r.epu[3*i +: 3]);
         cmt_pc[i]      = r.pc0 + PC_W'(i);
         cmt_fls_tgt[i] = r.fls_tgt;
         cmt_prd[i]     = r.prd0 + PRF_AW'(i);
      end
      cmt_valid     = r.valid;
      cmt_is_bcc    = r.bcc;
      cmt_is_breg   = '0;
      cmt_is_brel   = '0;
      cmt_fls       = r.fls;
      cmt_exc       = r.exc;
      cmt_prd_we    = r.prd_we;
      cmt_opera     = r.opera;
      cmt_operb     = r.operb;
      cmt_bpu_taken = r.taken;
      cmt_bpu_tgt   = r.bpu_tgt;
   endtask

   // Checks the cycle where slot 0 retires or the exception flush shows
   task automatic check_retire(input row_t r, input int cyc, input int n_req);
      logic uses_lsu;
      logic uses_epu;
      uses_lsu = (r.lsu[1:0] != 2'd0) && !r.exc[0];
      uses_epu = (r.epu[2:0] != 3'd0) || r.exc[0];
      compare_value("cmt_fire", 32'(cmt_fire), 32'(r.fire));
      compare_value("cmt_pop_size", 32'(cmt_pop_size), 32'(r.pop));
      compare_value("flush", 32'(flush), 32'(r.flush_at == 2'd1));
      if (r.flush_at == 2'd1)
         compare_value("flush_tgt", 32'(flush_tgt), 32'(r.tgt));
      compare_value("prf_we", 32'(prf_we), 32'(r.prf_we));
      if (r.prf_we)
      begin
         compare_value("prf_waddr", 32'(prf_waddr), 32'(r.prd0));
         compare_value("prf_wdata", prf_wdata, r.wdata);
      end
      compare_value("bpu_wb", 32'(bpu_wb), 32'(r.fire[0] & r.bcc[0]));
      if (r.fire[0] && r.bcc[0])
      begin
         compare_value("bpu_wb_taken", 32'(bpu_wb_taken), 32'(r.taken ^ r.fls[0]));
         compare_value("bpu_wb_npc_act", 32'(bpu_wb_npc_act),
                       32'(r.fls[0] ? r.fls_tgt : r.bpu_tgt));
         compare_value("bpu_wb_is_bcc", 32'(bpu_wb_is_bcc), 32'd1);
         compare_value("bpu_wb_is_breg", 32'(bpu_wb_is_breg), 32'd0);
         compare_value("bpu_wb_is_brel", 32'(bpu_wb_is_brel), 32'd0);
         compare_value("bpu_wb_pc", 32'(bpu_wb_pc), 32'(r.pc0));
      end
      compare_value("lsu_req count", 32'(n_req), 32'(uses_lsu));
      if (uses_epu)
         compare_value("retire cycle", 32'(cyc), 32'd1);   // Answer one cycle after req
      else if (uses_lsu)
         compare_value("lsu_done", 32'(lsu_done), 32'd1);
      else
         compare_value("retire cycle", 32'(cyc), 32'd0);
   endtask

   task automatic run_row(input row_t r);
      int   cyc;
      int   n_req;
      logic ended;
      cyc   = 0;
      n_req = 0;
      ended = 1'b0;
      @(posedge clk);
      #2;
      apply_row(r);
      while (!ended)   // Inputs hold until retire or flush
      begin
         @(negedge clk);
         if (lsu_req)
         begin
            n_req++;
            compare_value("lsu_addr", lsu_addr, r.opera);
            compare_value("lsu_op", 32'(lsu_op), 32'(r.lsu[1:0]));
            compare_value("lsu_wdat", lsu_wdat, r.operb);
         end
         if (cmt_fire != '0 || flush)
            ended = 1'b1;
         else
            cyc++;
      end
      check_retire(r, cyc, n_req);
      if (r.flush_at == 2'd2)
      begin
         @(negedge clk);
         compare_value("flush", 32'(flush), 32'd1);
         compare_value("flush_tgt", 32'(flush_tgt), 32'(r.tgt));
         compare_value("cmt_fire", 32'(cmt_fire), 32'd0);
      end
   endtask

   // Load/store responder with a random 1 to 4 cycle delay
   always @(negedge clk)
   begin
      if (!rst && lsu_req)
      begin
         ld_addr  = lsu_addr;
         ld_delay = 1 + int'($unsigned($random(seed)) % 4);
         repeat (ld_delay) @(posedge clk);
         #2;
         lsu_done  = 1'b1;
         lsu_rdata = ld_addr ^ LD_KEY;
         @(posedge clk);
         #2;
         lsu_done  = 1'b0;
      end
   end

   initial
   begin
      apply_row('0);
      load_table();
      repeat (3) @(posedge clk);
      #2;
      rst = 1'b0;
      for (int k = 0; k < NUM_ROWS; k++)
         run_row(tbl[k]);
      $display("Checks: %0d  Errors: %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * PERIOD);
      $display("Watchdog expired before the table finished, a row never retired");
      $display("Checks: %0d  Errors: %0d", n_checks, n_errors);
      $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verif
design/cmt_pkg.sv
design/cmt_epu_if.sv
design/cmt_msr_if.sv
design/cmt_msr.sv
design/cmt_epu.sv
design/cmt_flush_ctl.sv
design/cmt_fire_ctl.sv
design/cmt_top.sv
verif/tb_cmt.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the commit stage testbench with Verilator, run it, and search the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module tb_cmt -o tb_cmt_sim \
   && ./obj_dir/tb_cmt_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -qx '\*\* PASS \*\*' sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
